// ==== include/noc_settings.svh ====
/* NoC endpoint sizing
   Tile and group counts, field widths and router buffer depth */
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Group geometry
`define NUM_TILES   4
`define NUM_GROUPS  4   // Groups along the X row

// Payload and address widths
`define DATA_W      32
`define ADDR_W      12  // Word address within the group
`define ROW_OFF     8   // Tile select sits right above this
`define CORE_ID_W   3

// Router input buffering
`define FIFO_DEPTH  2

`endif

// ==== logic/noc_pkg.sv ====
/* NoC endpoint types
   Field typedefs, request flit layout and router port directions */
`include "noc_settings.svh"

package noc_pkg;

  // Identifiers
  typedef logic [$clog2(`NUM_TILES)-1:0]  tile_id_t;
  typedef logic [$clog2(`NUM_GROUPS)-1:0] group_id_t;

  // Addresses
  typedef logic [`ADDR_W-1:0]  addr_t;     // Group-level word address
  typedef logic [`ROW_OFF-1:0] row_addr_t; // Row inside one tile

  // Payload
  typedef logic [`DATA_W-1:0]   data_t;
  typedef logic [`DATA_W/8-1:0] be_t;
  typedef logic [`CORE_ID_W-1:0] core_id_t;

  // Request flit, header first
  typedef struct packed {
    tile_id_t  src_tile;   // Issuing tile
    group_id_t src_group;  // Issuing group
    group_id_t dst_group;  // Used by the X routers
    addr_t     tgt_addr;   // Used by the tile crossbar
    core_id_t  core_id;
    logic      wen;
    be_t       be;
    data_t     data;
  } flit_t;

  // Router ports, also used as port indices
  typedef enum logic [1:0] {
    LOCAL = 2'd0,
    EAST  = 2'd1,
    WEST  = 2'd2
  } dir_e;

endpackage

// ==== logic/flit_fifo.sv ====
`timescale 1ns/1ns
/* Flit buffer
   Small circular FIFO with valid/ready on both sides */
`include "noc_settings.svh"

module flit_fifo
  import noc_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_i,
  input  flit_t in_flit_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  output flit_t out_flit_o,
  output logic  out_valid_o,
  input  logic  out_ready_i
);

  localparam int unsigned DEPTH = `FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  flit_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign in_ready_o  = (count != CNT_W'(DEPTH)); // No write while full
  assign out_valid_o = (count != '0);
  assign out_flit_o  = mem[rd_ptr];              // Oldest entry

  assign push = in_valid_i & in_ready_o;
  assign pop  = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr] <= in_flit_i;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Idle or pass-through
      endcase
    end
  end

endmodule

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/1ns
/* Round-robin arbiter
   One-hot grant from a rotating pointer, grant held while the output stalls */
module rr_arbiter #(
  parameter int unsigned NUM_REQ = 3
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [NUM_REQ-1:0] req_i,
  output logic [NUM_REQ-1:0] gnt_o,
  output logic               valid_o,
  input  logic               ready_i
);

  localparam int unsigned IDX_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [IDX_W-1:0]   ptr_q;   // Highest priority requester
  logic [IDX_W-1:0]   win_idx;
  logic [NUM_REQ-1:0] rr_gnt;
  logic [NUM_REQ-1:0] gnt_q;
  logic               lock_q;  // Last grant stalled

  assign valid_o = |req_i;

  // First requester at or after the pointer
  always_comb begin
    int unsigned idx;
    logic        found;
    rr_gnt = '0;
    found  = 1'b0;
    for (int unsigned k = 0; k < NUM_REQ; k++) begin
      idx = (ptr_q + k) % NUM_REQ;
      if (!found && req_i[idx]) begin
        found       = 1'b1;
        rr_gnt[idx] = 1'b1;
      end
    end
  end

  // A stalled grant must not move, or the output flit would change
  assign gnt_o = lock_q ? gnt_q : rr_gnt;

  always_comb begin
    win_idx = ptr_q;
    for (int unsigned k = 0; k < NUM_REQ; k++) begin
      if (gnt_o[k]) win_idx = IDX_W'(k);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q  <= '0;
      gnt_q  <= '0;
      lock_q <= 1'b0;
    end else begin
      lock_q <= valid_o & ~ready_i;
      gnt_q  <= gnt_o;
      if (valid_o && ready_i) begin
        ptr_q <= (win_idx == IDX_W'(NUM_REQ - 1)) ? '0 : win_idx + 1'b1; // Skip past winner
      end
    end
  end

endmodule

// ==== logic/noc_router.sv ====
`timescale 1ns/1ns
/* Per-tile X router
   Packs the master request, buffers local/east/west inputs and routes on dst_group */
module noc_router
  import noc_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_i,
  input  group_id_t group_id_i,
  input  tile_id_t  tile_id_i,
  // Master request of this tile
  input  logic      mst_valid_i,
  input  group_id_t mst_tgt_group_i,
  input  addr_t     mst_tgt_addr_i,
  input  logic      mst_wen_i,
  input  be_t       mst_be_i,
  input  data_t     mst_data_i,
  input  core_id_t  mst_core_id_i,
  output logic      mst_ready_o,
  // Incoming links
  input  flit_t     east_flit_i,
  input  logic      east_valid_i,
  output logic      east_ready_o,
  input  flit_t     west_flit_i,
  input  logic      west_valid_i,
  output logic      west_ready_o,
  // Outgoing links
  output flit_t     east_flit_o,
  output logic      east_valid_o,
  input  logic      east_ready_i,
  output flit_t     west_flit_o,
  output logic      west_valid_o,
  input  logic      west_ready_i,
  // Ejection toward the tile crossbar
  output flit_t     eject_flit_o,
  output logic      eject_valid_o,
  input  logic      eject_ready_i
);

  localparam int unsigned NUM_PORTS = 3;

  flit_t [NUM_PORTS-1:0]                in_flit;
  logic  [NUM_PORTS-1:0]                in_valid;
  logic  [NUM_PORTS-1:0]                in_ready;
  flit_t [NUM_PORTS-1:0]                head_flit;
  logic  [NUM_PORTS-1:0]                head_valid;
  logic  [NUM_PORTS-1:0]                head_ready;
  dir_e                                 route [NUM_PORTS];
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] req;  // [output][input]
  logic  [NUM_PORTS-1:0][NUM_PORTS-1:0] gnt;
  flit_t [NUM_PORTS-1:0]                out_flit;
  logic  [NUM_PORTS-1:0]                out_valid;
  logic  [NUM_PORTS-1:0]                out_ready;

  // Pack the master request
  assign in_flit[LOCAL] = '{
    src_tile : tile_id_i,
    src_group: group_id_i,
    dst_group: mst_tgt_group_i,
    tgt_addr : mst_tgt_addr_i,
    core_id  : mst_core_id_i,
    wen      : mst_wen_i,
    be       : mst_be_i,
    data     : mst_data_i
  };
  assign in_valid[LOCAL] = mst_valid_i;
  assign in_flit[EAST]   = east_flit_i;
  assign in_valid[EAST]  = east_valid_i;
  assign in_flit[WEST]   = west_flit_i;
  assign in_valid[WEST]  = west_valid_i;

  assign mst_ready_o  = in_ready[LOCAL];
  assign east_ready_o = in_ready[EAST];
  assign west_ready_o = in_ready[WEST];

  for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_in_fifo
    flit_fifo i_fifo (
      .clk_i      (clk_i        ),
      .rst_i      (rst_i        ),
      .in_flit_i  (in_flit[p]   ),
      .in_valid_i (in_valid[p]  ),
      .in_ready_o (in_ready[p]  ),
      .out_flit_o (head_flit[p] ),
      .out_valid_o(head_valid[p]),
      .out_ready_i(head_ready[p])
    );
  end

  // X routing on the buffered heads
  always_comb begin
    if (head_flit[LOCAL].dst_group > group_id_i) route[LOCAL] = EAST;
    else if (head_flit[LOCAL].dst_group < group_id_i) route[LOCAL] = WEST;
    else route[LOCAL] = LOCAL;
    // Link traffic keeps its direction or ejects, never turns back
    if (head_flit[EAST].dst_group < group_id_i) route[EAST] = WEST;
    else route[EAST] = LOCAL;
    if (head_flit[WEST].dst_group > group_id_i) route[WEST] = EAST;
    else route[WEST] = LOCAL;
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : gen_out
    flit_t sel_flit;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_req
      assign req[o][p] = head_valid[p] && (route[p] == dir_e'(o));
    end

    rr_arbiter #(
      .NUM_REQ(NUM_PORTS)
    ) i_arb (
      .clk_i  (clk_i       ),
      .rst_i  (rst_i       ),
      .req_i  (req[o]      ),
      .gnt_o  (gnt[o]      ),
      .valid_o(out_valid[o]),
      .ready_i(out_ready[o])
    );

    always_comb begin
      sel_flit = '0;
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (gnt[o][p]) sel_flit = head_flit[p];
      end
    end

    assign out_flit[o] = sel_flit;
  end

  // Ready goes back only to the granted input
  always_comb begin
    head_ready = '0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (gnt[o][p] && out_ready[o]) head_ready[p] = 1'b1;
      end
    end
  end

  assign eject_flit_o     = out_flit[LOCAL];
  assign eject_valid_o    = out_valid[LOCAL];
  assign out_ready[LOCAL] = eject_ready_i;
  assign east_flit_o      = out_flit[EAST];
  assign east_valid_o     = out_valid[EAST];
  assign out_ready[EAST]  = east_ready_i;
  assign west_flit_o      = out_flit[WEST];
  assign west_valid_o     = out_valid[WEST];
  assign out_ready[WEST]  = west_ready_i;

endmodule

// ==== logic/tile_xbar.sv ====
`timescale 1ns/1ns
/* Tile request crossbar
   Steers ejected flits to the tile named by the address tile bits and unpacks them */
`include "noc_settings.svh"

module tile_xbar
  import noc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  // From the routers
  input  flit_t     [`NUM_TILES-1:0] eject_flit_i,
  input  logic      [`NUM_TILES-1:0] eject_valid_i,
  output logic      [`NUM_TILES-1:0] eject_ready_o,
  // Tile slave ports
  output logic      [`NUM_TILES-1:0] slv_valid_o,
  input  logic      [`NUM_TILES-1:0] slv_ready_i,
  output row_addr_t [`NUM_TILES-1:0] slv_row_addr_o,
  output logic      [`NUM_TILES-1:0] slv_wen_o,
  output be_t       [`NUM_TILES-1:0] slv_be_o,
  output data_t     [`NUM_TILES-1:0] slv_data_o,
  output core_id_t  [`NUM_TILES-1:0] slv_core_id_o,
  output tile_id_t  [`NUM_TILES-1:0] slv_src_tile_o,
  output group_id_t [`NUM_TILES-1:0] slv_src_group_o
);

  localparam int unsigned NT     = `NUM_TILES;
  localparam int unsigned TILE_W = $bits(tile_id_t);

  tile_id_t [NT-1:0]         tgt_tile;
  logic     [NT-1:0][NT-1:0] req;  // [tile][input]
  logic     [NT-1:0][NT-1:0] gnt;

  for (genvar i = 0; i < NT; i++) begin : gen_decode
    assign tgt_tile[i] = eject_flit_i[i].tgt_addr[`ROW_OFF +: TILE_W];
  end

  for (genvar t = 0; t < NT; t++) begin : gen_tile
    flit_t sel_flit;

    for (genvar i = 0; i < NT; i++) begin : gen_req
      assign req[t][i] = eject_valid_i[i] && (tgt_tile[i] == tile_id_t'(t));
    end

    rr_arbiter #(
      .NUM_REQ(NT)
    ) i_arb (
      .clk_i  (clk_i         ),
      .rst_i  (rst_i         ),
      .req_i  (req[t]        ),
      .gnt_o  (gnt[t]        ),
      .valid_o(slv_valid_o[t]),
      .ready_i(slv_ready_i[t])
    );

    always_comb begin
      sel_flit = '0;
      for (int i = 0; i < NT; i++) begin
        if (gnt[t][i]) sel_flit = eject_flit_i[i];
      end
    end

    // Unpack, the row address loses the tile select bits
    assign slv_row_addr_o[t]  = sel_flit.tgt_addr[`ROW_OFF-1:0];
    assign slv_wen_o[t]       = sel_flit.wen;
    assign slv_be_o[t]        = sel_flit.be;
    assign slv_data_o[t]      = sel_flit.data;
    assign slv_core_id_o[t]   = sel_flit.core_id;
    assign slv_src_tile_o[t]  = sel_flit.src_tile;   // Kept for the response
    assign slv_src_group_o[t] = sel_flit.src_group;
  end

  always_comb begin
    eject_ready_o = '0;
    for (int t = 0; t < NT; t++) begin
      for (int i = 0; i < NT; i++) begin
        if (gnt[t][i] && slv_ready_i[t]) eject_ready_o[i] = 1'b1;
      end
    end
  end

endmodule

// ==== logic/group_noc_endpoint.sv ====
`timescale 1ns/1ns
/* Group NoC endpoint
   One X router per tile plus the tile crossbar on the ejection side */
`include "noc_settings.svh"

module group_noc_endpoint
  import noc_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  group_id_t                  group_id_i,
  // Master requests
  input  logic      [`NUM_TILES-1:0] mst_valid_i,
  input  group_id_t [`NUM_TILES-1:0] mst_tgt_group_i,
  input  addr_t     [`NUM_TILES-1:0] mst_tgt_addr_i,
  input  logic      [`NUM_TILES-1:0] mst_wen_i,
  input  be_t       [`NUM_TILES-1:0] mst_be_i,
  input  data_t     [`NUM_TILES-1:0] mst_data_i,
  input  core_id_t  [`NUM_TILES-1:0] mst_core_id_i,
  output logic      [`NUM_TILES-1:0] mst_ready_o,
  // Links in
  input  flit_t     [`NUM_TILES-1:0] east_flit_i,
  input  logic      [`NUM_TILES-1:0] east_valid_i,
  output logic      [`NUM_TILES-1:0] east_ready_o,
  input  flit_t     [`NUM_TILES-1:0] west_flit_i,
  input  logic      [`NUM_TILES-1:0] west_valid_i,
  output logic      [`NUM_TILES-1:0] west_ready_o,
  // Links out
  output flit_t     [`NUM_TILES-1:0] east_flit_o,
  output logic      [`NUM_TILES-1:0] east_valid_o,
  input  logic      [`NUM_TILES-1:0] east_ready_i,
  output flit_t     [`NUM_TILES-1:0] west_flit_o,
  output logic      [`NUM_TILES-1:0] west_valid_o,
  input  logic      [`NUM_TILES-1:0] west_ready_i,
  // Slave requests
  output logic      [`NUM_TILES-1:0] slv_valid_o,
  input  logic      [`NUM_TILES-1:0] slv_ready_i,
  output row_addr_t [`NUM_TILES-1:0] slv_row_addr_o,
  output logic      [`NUM_TILES-1:0] slv_wen_o,
  output be_t       [`NUM_TILES-1:0] slv_be_o,
  output data_t     [`NUM_TILES-1:0] slv_data_o,
  output core_id_t  [`NUM_TILES-1:0] slv_core_id_o,
  output tile_id_t  [`NUM_TILES-1:0] slv_src_tile_o,
  output group_id_t [`NUM_TILES-1:0] slv_src_group_o
);

  flit_t [`NUM_TILES-1:0] eject_flit;
  logic  [`NUM_TILES-1:0] eject_valid;
  logic  [`NUM_TILES-1:0] eject_ready;

  for (genvar i = 0; i < `NUM_TILES; i++) begin : gen_router
    noc_router i_router (
      .clk_i          (clk_i             ),
      .rst_i          (rst_i             ),
      .group_id_i     (group_id_i        ),
      .tile_id_i      (tile_id_t'(i)     ), // Router index is the source tile
      .mst_valid_i    (mst_valid_i[i]    ),
      .mst_tgt_group_i(mst_tgt_group_i[i]),
      .mst_tgt_addr_i (mst_tgt_addr_i[i] ),
      .mst_wen_i      (mst_wen_i[i]      ),
      .mst_be_i       (mst_be_i[i]       ),
      .mst_data_i     (mst_data_i[i]     ),
      .mst_core_id_i  (mst_core_id_i[i]  ),
      .mst_ready_o    (mst_ready_o[i]    ),
      .east_flit_i    (east_flit_i[i]    ),
      .east_valid_i   (east_valid_i[i]   ),
      .east_ready_o   (east_ready_o[i]   ),
      .west_flit_i    (west_flit_i[i]    ),
      .west_valid_i   (west_valid_i[i]   ),
      .west_ready_o   (west_ready_o[i]   ),
      .east_flit_o    (east_flit_o[i]    ),
      .east_valid_o   (east_valid_o[i]   ),
      .east_ready_i   (east_ready_i[i]   ),
      .west_flit_o    (west_flit_o[i]    ),
      .west_valid_o   (west_valid_o[i]   ),
      .west_ready_i   (west_ready_i[i]   ),
      .eject_flit_o   (eject_flit[i]     ),
      .eject_valid_o  (eject_valid[i]    ),
      .eject_ready_i  (eject_ready[i]    )
    );
  end

  tile_xbar i_xbar (
    .clk_i          (clk_i          ),
    .rst_i          (rst_i          ),
    .eject_flit_i   (eject_flit     ),
    .eject_valid_i  (eject_valid    ),
    .eject_ready_o  (eject_ready    ),
    .slv_valid_o    (slv_valid_o    ),
    .slv_ready_i    (slv_ready_i    ),
    .slv_row_addr_o (slv_row_addr_o ),
    .slv_wen_o      (slv_wen_o      ),
    .slv_be_o       (slv_be_o       ),
    .slv_data_o     (slv_data_o     ),
    .slv_core_id_o  (slv_core_id_o  ),
    .slv_src_tile_o (slv_src_tile_o ),
    .slv_src_group_o(slv_src_group_o)
  );

endmodule

// ==== verif/group_noc_endpoint_sva.sv ====
`timescale 1ns/1ns
/* Handshake assertions for the group NoC endpoint
   Valid and payload hold while stalled, outputs quiet in reset */
`include "noc_settings.svh"

module group_noc_endpoint_sva
  import noc_pkg::*;
(
  input logic                       clk_i,
  input logic                       rst_i,
  input logic      [`NUM_TILES-1:0] slv_valid_o,
  input logic      [`NUM_TILES-1:0] slv_ready_i,
  input row_addr_t [`NUM_TILES-1:0] slv_row_addr_o,
  input data_t     [`NUM_TILES-1:0] slv_data_o,
  input flit_t     [`NUM_TILES-1:0] east_flit_o,
  input logic      [`NUM_TILES-1:0] east_valid_o,
  input logic      [`NUM_TILES-1:0] east_ready_i,
  input flit_t     [`NUM_TILES-1:0] west_flit_o,
  input logic      [`NUM_TILES-1:0] west_valid_o,
  input logic      [`NUM_TILES-1:0] west_ready_i
);

  logic rst_q;  // Reset seen on the previous edge

  always_ff @(posedge clk_i) rst_q <= rst_i;

  for (genvar i = 0; i < `NUM_TILES; i++) begin : gen_tile
    assert property (@(posedge clk_i) disable iff (rst_i)
      slv_valid_o[i] && !slv_ready_i[i] |=> slv_valid_o[i])
      else $error("slave port %0d dropped valid before ready", i);
    assert property (@(posedge clk_i) disable iff (rst_i)
      slv_valid_o[i] && !slv_ready_i[i] |=> $stable(slv_data_o[i]) && $stable(slv_row_addr_o[i]))
      else $error("slave port %0d changed its request while stalled", i);
    assert property (@(posedge clk_i) disable iff (rst_i)
      east_valid_o[i] && !east_ready_i[i] |=> east_valid_o[i] && $stable(east_flit_o[i]))
      else $error("east link %0d changed valid or flit while stalled", i);
    assert property (@(posedge clk_i) disable iff (rst_i)
      west_valid_o[i] && !west_ready_i[i] |=> west_valid_o[i] && $stable(west_flit_o[i]))
      else $error("west link %0d changed valid or flit while stalled", i);
  end

  assert property (@(posedge clk_i)
    rst_i && rst_q |-> slv_valid_o == '0 && east_valid_o == '0 && west_valid_o == '0)
    else $error("valid output high during reset");

endmodule

bind group_noc_endpoint group_noc_endpoint_sva i_sva (
  .clk_i         (clk_i         ),
  .rst_i         (rst_i         ),
  .slv_valid_o   (slv_valid_o   ),
  .slv_ready_i   (slv_ready_i   ),
  .slv_row_addr_o(slv_row_addr_o),
  .slv_data_o    (slv_data_o    ),
  .east_flit_o   (east_flit_o   ),
  .east_valid_o  (east_valid_o  ),
  .east_ready_i  (east_ready_i  ),
  .west_flit_o   (west_flit_o   ),
  .west_valid_o  (west_valid_o  ),
  .west_ready_i  (west_ready_i  )
);

// ==== verif/tb_group_noc_endpoint.sv ====
`timescale 1ns/1ns
/* Group NoC endpoint testbench
   Random master and link traffic checked against a routing model with per-path queues */
`include "noc_settings.svh"

module tb_group_noc_endpoint
  import noc_pkg::*;
();

  localparam int        NT           = `NUM_TILES;
  localparam int        NSRC         = 3 * NT;  // Local, east in, west in per tile
  localparam int        NDST         = 3 * NT;  // Slave ports, east out, west out
  localparam int        TILE_W       = $bits(tile_id_t);
  localparam group_id_t GROUP_ID     = group_id_t'(1);
  localparam int        LIGHT_TXN    = 120;
  localparam int        STRESS_TXN   = 600;
  localparam int        TOTAL_TXN    = LIGHT_TXN + STRESS_TXN;
  localparam int        DRAIN_CYCLES = 400;

  logic                clk_i = 1'b0;
  logic                rst_i;
  logic      [NT-1:0]  mst_valid_i;
  group_id_t [NT-1:0]  mst_tgt_group_i;
  addr_t     [NT-1:0]  mst_tgt_addr_i;
  logic      [NT-1:0]  mst_wen_i;
  be_t       [NT-1:0]  mst_be_i;
  data_t     [NT-1:0]  mst_data_i;
  core_id_t  [NT-1:0]  mst_core_id_i;
  logic      [NT-1:0]  mst_ready_o;
  flit_t     [NT-1:0]  east_flit_i;
  logic      [NT-1:0]  east_valid_i;
  logic      [NT-1:0]  east_ready_o;
  flit_t     [NT-1:0]  west_flit_i;
  logic      [NT-1:0]  west_valid_i;
  logic      [NT-1:0]  west_ready_o;
  flit_t     [NT-1:0]  east_flit_o;
  logic      [NT-1:0]  east_valid_o;
  logic      [NT-1:0]  east_ready_i;
  flit_t     [NT-1:0]  west_flit_o;
  logic      [NT-1:0]  west_valid_o;
  logic      [NT-1:0]  west_ready_i;
  logic      [NT-1:0]  slv_valid_o;
  logic      [NT-1:0]  slv_ready_i;
  row_addr_t [NT-1:0]  slv_row_addr_o;
  logic      [NT-1:0]  slv_wen_o;
  be_t       [NT-1:0]  slv_be_o;
  data_t     [NT-1:0]  slv_data_o;
  core_id_t  [NT-1:0]  slv_core_id_o;
  tile_id_t  [NT-1:0]  slv_src_tile_o;
  group_id_t [NT-1:0]  slv_src_group_o;

  // One scoreboard queue per source port and destination port
  flit_t       exp_q [NSRC*NDST][$];
  int          outstanding = 0;
  int          injected;
  int          inj_target;
  int unsigned err_value = 0;
  int unsigned err_other = 0;
  logic [NT-1:0] mst_taken;
  logic [NT-1:0] east_taken;
  logic [NT-1:0] west_taken;
  logic [15:0] tag = '0;                  // Unique per flit in the low data half
  logic [31:0] lfsr_state = 32'hadc12bc9;

  group_noc_endpoint group_noc_endpoint_inst (
    .clk_i, .rst_i, .group_id_i(GROUP_ID),
    .mst_valid_i, .mst_tgt_group_i, .mst_tgt_addr_i, .mst_wen_i, .mst_be_i,
    .mst_data_i, .mst_core_id_i, .mst_ready_o,
    .east_flit_i, .east_valid_i, .east_ready_o,
    .west_flit_i, .west_valid_i, .west_ready_o,
    .east_flit_o, .east_valid_o, .east_ready_i,
    .west_flit_o, .west_valid_o, .west_ready_i,
    .slv_valid_o, .slv_ready_i, .slv_row_addr_o, .slv_wen_o, .slv_be_o,
    .slv_data_o, .slv_core_id_o, .slv_src_tile_o, .slv_src_group_o
  );

  always #10 clk_i = ~clk_i;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] next_rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned k = 0; k < n; k++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'ha3000000) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic data_t tagged_data();
    logic [31:0] r;
    r = next_rand_bits(16);
    tag++;
    return {r[15:0], tag};
  endfunction

  // East neighbor sends westward to group 0 or 1 and west neighbor eastward to 1..3
  function automatic flit_t make_link_flit(bit from_east);
    flit_t       f;
    logic [31:0] r;
    f.src_tile  = tile_id_t'(next_rand_bits(TILE_W));
    f.src_group = group_id_t'(next_rand_bits(2));
    if (from_east) begin
      f.dst_group = group_id_t'(next_rand_bits(1));
    end else begin
      r = next_rand_bits(2);
      f.dst_group = (r[1:0] == 2'd0) ? GROUP_ID : group_id_t'(r[1:0]);
    end
    f.tgt_addr = addr_t'(next_rand_bits(`ADDR_W));
    f.core_id  = core_id_t'(next_rand_bits(`CORE_ID_W));
    f.wen      = next_rand_bits(1) != 0;
    f.be       = be_t'(next_rand_bits($bits(be_t)));
    f.data     = tagged_data();
    return f;
  endfunction

  // Packing rule for a master request of tile i
  function automatic flit_t pack_master(int i);
    flit_t f;
    f.src_tile  = tile_id_t'(i);
    f.src_group = GROUP_ID;
    f.dst_group = mst_tgt_group_i[i];
    f.tgt_addr  = mst_tgt_addr_i[i];
    f.core_id   = mst_core_id_i[i];
    f.wen       = mst_wen_i[i];
    f.be        = mst_be_i[i];
    f.data      = mst_data_i[i];
    return f;
  endfunction

  function automatic int dest_of(int tile, flit_t f);
    if (f.dst_group == GROUP_ID) return int'(f.tgt_addr[`ROW_OFF +: TILE_W]); // Slave tile
    else if (f.dst_group > GROUP_ID) return NT + tile;
    else return 2 * NT + tile;
  endfunction

  // Fields that survive the crossbar with tgt_addr cut down to tile and row
  function automatic flit_t slave_view(flit_t f);
    flit_t v;
    v           = f;
    v.dst_group = '0;
    v.tgt_addr  = addr_t'(f.tgt_addr[`ROW_OFF+TILE_W-1:0]);
    return v;
  endfunction

  function automatic bit pop_match(int dst, data_t d, output flit_t want);
    flit_t head;
    for (int s = 0; s < NSRC; s++) begin
      if (exp_q[s*NDST+dst].size() != 0) begin
        head = exp_q[s*NDST+dst][0];
        if (head.data == d) begin
          want = exp_q[s*NDST+dst].pop_front();
          outstanding--;
          return 1'b1;
        end
      end
    end
    want = '0;
    return 1'b0;
  endfunction

  task automatic check_flit(string name, flit_t want, flit_t got);
    if (want !== got) begin
      err_value++;
      $display("FAIL %s: expected %h, actual %h", name, want, got);
    end
  endtask

  task automatic check_row(string name, row_addr_t want, row_addr_t got);
    if (want !== got) begin
      err_value++;
      $display("FAIL %s row: expected %h, actual %h", name, want, got);
    end
  endtask

  task automatic check_tile(string name, tile_id_t want, tile_id_t got);
    if (want !== got) begin
      err_value++;
      $display("FAIL %s src_tile: expected %0d, actual %0d", name, want, got);
    end
  endtask

  task automatic report_unmatched(string name, data_t d);
    err_other++;
    $display("ERROR: %s delivered data %h that was never sent or overtook an older flit",
             name, d);
  endtask

  task automatic push_expected(int src, int tile, flit_t f);
    exp_q[src*NDST + dest_of(tile, f)].push_back(f);
    outstanding++;
  endtask

  task automatic check_link(string name, int dst, flit_t got);
    flit_t want;
    if (!pop_match(dst, got.data, want)) report_unmatched(name, got.data);
    else check_flit(name, want, got);
  endtask

  task automatic check_slave(string name, int t);
    flit_t want;
    flit_t got;
    if (!pop_match(t, slv_data_o[t], want)) begin
      report_unmatched(name, slv_data_o[t]);
    end else begin
      got.src_tile  = slv_src_tile_o[t];
      got.src_group = slv_src_group_o[t];
      got.dst_group = '0;
      got.tgt_addr  = addr_t'({tile_id_t'(t), slv_row_addr_o[t]}); // Port gives the tile
      got.core_id   = slv_core_id_o[t];
      got.wen       = slv_wen_o[t];
      got.be        = slv_be_o[t];
      got.data      = slv_data_o[t];
      check_row(name, want.tgt_addr[`ROW_OFF-1:0], slv_row_addr_o[t]);
      check_tile(name, want.src_tile, slv_src_tile_o[t]);
      check_flit(name, slave_view(want), got);
    end
  endtask

  // Records at mid-cycle what transfers on the next edge
  task automatic sample_and_check(string phase);
    // Outputs first, since an input taken on this edge must not leave on it
    for (int i = 0; i < NT; i++) begin
      if (slv_valid_o[i] && slv_ready_i[i]) check_slave($sformatf("%s slv%0d", phase, i), i);
      if (east_valid_o[i] && east_ready_i[i]) begin
        check_link($sformatf("%s east%0d", phase, i), NT + i, east_flit_o[i]);
      end
      if (west_valid_o[i] && west_ready_i[i]) begin
        check_link($sformatf("%s west%0d", phase, i), 2 * NT + i, west_flit_o[i]);
      end
    end
    mst_taken  = mst_valid_i & mst_ready_o;
    east_taken = east_valid_i & east_ready_o;
    west_taken = west_valid_i & west_ready_o;
    for (int i = 0; i < NT; i++) begin
      if (mst_taken[i]) push_expected(3 * i, i, pack_master(i));
      if (east_taken[i]) push_expected(3 * i + 1, i, east_flit_i[i]);
      if (west_taken[i]) push_expected(3 * i + 2, i, west_flit_i[i]);
    end
  endtask

  function automatic bit want_new(bit allow_new, int inj_bits);
    return allow_new && injected < inj_target && next_rand_bits(inj_bits) == 0;
  endfunction

  task automatic drive_inputs(bit allow_new, bit rand_ready, int inj_bits);
    for (int i = 0; i < NT; i++) begin
      if (mst_taken[i]) mst_valid_i[i] = 1'b0;   // Otherwise held until accepted
      if (east_taken[i]) east_valid_i[i] = 1'b0;
      if (west_taken[i]) west_valid_i[i] = 1'b0;
      if (!mst_valid_i[i] && want_new(allow_new, inj_bits)) begin
        mst_tgt_group_i[i] = group_id_t'(next_rand_bits(2));
        mst_tgt_addr_i[i]  = addr_t'(next_rand_bits(`ADDR_W));
        mst_wen_i[i]       = next_rand_bits(1) != 0;
        mst_be_i[i]        = be_t'(next_rand_bits($bits(be_t)));
        mst_core_id_i[i]   = core_id_t'(next_rand_bits(`CORE_ID_W));
        mst_data_i[i]      = tagged_data();
        mst_valid_i[i]     = 1'b1;
        injected++;
      end
      if (!east_valid_i[i] && want_new(allow_new, inj_bits)) begin
        east_flit_i[i]  = make_link_flit(1'b1);
        east_valid_i[i] = 1'b1;
        injected++;
      end
      if (!west_valid_i[i] && want_new(allow_new, inj_bits)) begin
        west_flit_i[i]  = make_link_flit(1'b0);
        west_valid_i[i] = 1'b1;
        injected++;
      end
    end
    slv_ready_i  = rand_ready ? NT'(next_rand_bits(NT)) : '1;
    east_ready_i = rand_ready ? NT'(next_rand_bits(NT)) : '1;
    west_ready_i = rand_ready ? NT'(next_rand_bits(NT)) : '1;
  endtask

  task automatic run_phase(string phase, int num_txn, int inj_bits, bit rand_ready);
    int idle;
    injected   = 0;
    inj_target = num_txn;
    idle       = 0;
    while (injected < num_txn) begin
      @(negedge clk_i);
      sample_and_check(phase);
      @(posedge clk_i);
      #2;
      drive_inputs(1'b1, rand_ready, inj_bits);
    end
    // Drain while pending valids stay up until taken
    while ((outstanding != 0 || (|mst_valid_i) || (|east_valid_i) || (|west_valid_i))
           && idle < DRAIN_CYCLES) begin
      @(negedge clk_i);
      sample_and_check(phase);
      @(posedge clk_i);
      #2;
      drive_inputs(1'b0, rand_ready, inj_bits);
      idle++;
    end
    if ((|mst_valid_i) || (|east_valid_i) || (|west_valid_i)) begin
      err_other++;
      $display("ERROR: %s phase ended with requests that were never accepted", phase);
    end
  endtask

  task automatic check_queues_empty();
    for (int s = 0; s < NSRC; s++) begin
      for (int d = 0; d < NDST; d++) begin
        if (exp_q[s*NDST+d].size() != 0) begin
          err_other++;
          $display("ERROR: %0d flit(s) from source port %0d never reached destination port %0d",
                   exp_q[s*NDST+d].size(), s, d);
        end
      end
    end
  endtask

  // Watchdog allowing 40 cycles per transaction
  initial begin
    #(TOTAL_TXN * 40 * 20);
    $display("ERROR: watchdog expired after %0d ns with %0d flits in flight",
             TOTAL_TXN * 40 * 20, outstanding);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    rst_i           = 1'b1;
    mst_valid_i     = '0;
    mst_tgt_group_i = '0;
    mst_tgt_addr_i  = '0;
    mst_wen_i       = '0;
    mst_be_i        = '0;
    mst_data_i      = '0;
    mst_core_id_i   = '0;
    east_flit_i     = '0;
    east_valid_i    = '0;
    west_flit_i     = '0;
    west_valid_i    = '0;
    east_ready_i    = '0;
    west_ready_i    = '0;
    slv_ready_i     = '0;
    mst_taken       = '0;
    east_taken      = '0;
    west_taken      = '0;
    repeat (7) begin
      @(negedge clk_i);
      if (slv_valid_o !== '0 || east_valid_o !== '0 || west_valid_o !== '0) begin
        err_other++;
        $display("ERROR: a valid output is high while reset is asserted");
      end
    end
    @(posedge clk_i);
    #2;
    rst_i = 1'b0;   // Eight edges in reset

    run_phase("light", LIGHT_TXN, 5, 1'b0);
    run_phase("stress", STRESS_TXN, 1, 1'b1);
    check_queues_empty();

    $display("Errors: %0d value mismatches, %0d other failures", err_value, err_other);
    if (err_value == 0 && err_other == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+include
logic/noc_pkg.sv
logic/flit_fifo.sv
logic/rr_arbiter.sv
logic/noc_router.sv
logic/tile_xbar.sv
logic/group_noc_endpoint.sv
verif/group_noc_endpoint_sva.sv
verif/tb_group_noc_endpoint.sv

// ==== Makefile ====
BIN := obj_dir/Vtb_group_noc_endpoint
SRC := $(wildcard include/*.svh logic/*.sv verif/*.sv)

.PHONY: all run clean

all: run

$(BIN): vlog.f $(SRC)
	verilator --binary --timing --assert --timescale 1ns/1ns -f vlog.f \
	  --top-module tb_group_noc_endpoint -o Vtb_group_noc_endpoint

run: $(BIN)
	./$(BIN) | awk '{ print } /^Simulation PASSED$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
